//--- logic/rf_pkg.sv
package rf_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Datapath width
    localparam int XLEN       = 32;
    // Register index width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    // Pending write counter width, saturates at 3
    localparam int PEND_W     = 2;
    // Result queue entries, also the issue credit count
    localparam int RQ_DEPTH   = 4;
    // Initial credits of the write-back sink
    localparam int WB_CREDITS = 2;
    // Issue to queue entry in cycles
    localparam int ALU_LAT    = 2;

    // Derived widths
    localparam int RQ_PTR_W   = $clog2(RQ_DEPTH);
    localparam int RQ_CNT_W   = $clog2(RQ_DEPTH + 1);
    localparam int WB_CNT_W   = $clog2(WB_CREDITS + 1);
    localparam int SHAMT_W    = $clog2(XLEN);

    // ----------------------------------------
    // Basic types
    // ----------------------------------------

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [PEND_W-1:0]     pend_t;
    typedef logic [RQ_PTR_W-1:0]   rq_ptr_t;
    typedef logic [RQ_CNT_W-1:0]   rq_cnt_t;
    typedef logic [WB_CNT_W-1:0]   wb_cnt_t;

    // ALU opcodes
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL
    } alu_op_e;

    // ----------------------------------------
    // Grouped signals
    // ----------------------------------------

    // Decoded instruction at the issue port
    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     read_rs1;
        logic     read_rs2;
        reg_idx_t rd;
        logic     write_rd;
        logic     use_imm;
        word_t    imm;
    } issue_req_t;

    // Request into the ALU pipeline
    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        logic     write_rd;
        word_t    a;
        word_t    b;
    } exec_req_t;

    // Result leaving the queue
    typedef struct packed {
        reg_idx_t rd;
        logic     write_rd;
        word_t    data;
    } wb_t;

endpackage

//--- logic/reg_storage.sv
`timescale 1ns/1ns

module reg_storage (
    input  logic             clk_i,
    input  logic             rst_i,

    // Read ports
    input  rf_pkg::reg_idx_t rs1_addr_i,
    input  rf_pkg::reg_idx_t rs2_addr_i,
    output rf_pkg::word_t    rs1_data_o,
    output rf_pkg::word_t    rs2_data_o,

    // Write port from write-back
    input  logic             wb_fire_i,
    input  rf_pkg::wb_t      wb_i
);

    // Register array
    rf_pkg::word_t regs_q [rf_pkg::NUM_REGS];
    logic          we;

    // x0 is never a write target
    assign we = wb_fire_i && wb_i.write_rd && (wb_i.rd != '0);

    // ----------------------------------------
    // Write
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < rf_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // Combinational reads
    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Zero register holds zero whatever write-back targets
    a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
        regs_q[0] == '0);

endmodule

//--- logic/reg_scoreboard.sv
`timescale 1ns/1ns

module reg_scoreboard (
    input  logic             clk_i,
    input  logic             rst_i,

    // Lookup indices from the issue port
    input  rf_pkg::reg_idx_t rs1_i,
    input  rf_pkg::reg_idx_t rs2_i,
    input  rf_pkg::reg_idx_t rd_i,

    // Increment on issue
    input  logic             issue_fire_i,
    input  logic             issue_write_i,

    // Decrement on write-back
    input  logic             wb_fire_i,
    input  rf_pkg::wb_t      wb_i,

    // Status flags
    output logic             busy1_o,
    output logic             busy2_o,
    output logic             last1_o,
    output logic             last2_o,
    output logic             rd_full_o
);

    // One pending write counter per register
    rf_pkg::pend_t pend_q [rf_pkg::NUM_REGS];

    logic inc;
    logic dec;
    logic same_reg;

    // Writes to x0 are not tracked
    assign inc      = issue_fire_i && issue_write_i && (rd_i != '0);
    assign dec      = wb_fire_i && wb_i.write_rd && (wb_i.rd != '0);
    assign same_reg = (rd_i == wb_i.rd);

    // ----------------------------------------
    // Counter update
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < rf_pkg::NUM_REGS; i++) begin
                pend_q[i] <= '0;
            end
        end else begin
            // Increment and decrement on one counter cancel
            if (inc && !(dec && same_reg)) begin
                pend_q[rd_i] <= pend_q[rd_i] + rf_pkg::pend_t'(1);
            end
            if (dec && !(inc && same_reg)) begin
                pend_q[wb_i.rd] <= pend_q[wb_i.rd] - rf_pkg::pend_t'(1);
            end
        end
    end

    // Flags
    assign busy1_o   = (pend_q[rs1_i] != '0);
    assign busy2_o   = (pend_q[rs2_i] != '0);
    assign last1_o   = (pend_q[rs1_i] == rf_pkg::pend_t'(1));
    assign last2_o   = (pend_q[rs2_i] == rf_pkg::pend_t'(1));
    assign rd_full_o = (pend_q[rd_i] == '1);

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Issue must stall on a saturated destination
    a_no_inc_sat: assert property (@(posedge clk_i) disable iff (!rst_i)
        (inc && !(dec && same_reg)) |-> (pend_q[rd_i] != '1));

    // Write-back only for registers that were issued
    a_no_dec_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
        dec |-> (pend_q[wb_i.rd] != '0));

endmodule

//--- logic/operand_issue.sv
`timescale 1ns/1ns

module operand_issue (
    input  logic               clk_i,
    input  logic               rst_i,

    // Issue port
    input  logic               issue_valid_i,
    input  rf_pkg::issue_req_t issue_i,
    output logic               stall_o,

    // Storage read ports
    output rf_pkg::reg_idx_t   rs1_addr_o,
    output rf_pkg::reg_idx_t   rs2_addr_o,
    input  rf_pkg::word_t      rs1_data_i,
    input  rf_pkg::word_t      rs2_data_i,

    // Scoreboard flags
    input  logic               busy1_i,
    input  logic               busy2_i,
    input  logic               last1_i,
    input  logic               last2_i,
    input  logic               rd_full_i,

    // Write-back forward
    input  logic               wb_fire_i,
    input  rf_pkg::wb_t        wb_i,

    // Queue credit return
    input  logic               rq_credit_i,

    // To the ALU pipeline
    output logic               issue_fire_o,
    output rf_pkg::exec_req_t  exec_o
);

    rf_pkg::rq_cnt_t rq_cred_q;
    rf_pkg::word_t   op_a;
    rf_pkg::word_t   op_b;

    logic wb_write;
    logic fwd1;
    logic fwd2;
    logic haz1;
    logic haz2;
    logic rd_block;
    logic no_credit;

    assign rs1_addr_o = issue_i.rs1;
    assign rs2_addr_o = issue_i.rs2;

    // ----------------------------------------
    // Hazards and forwarding
    // ----------------------------------------

    assign wb_write = wb_fire_i && wb_i.write_rd;

    // Last pending write is leaving now
    assign fwd1 = busy1_i && last1_i && wb_write && (wb_i.rd == issue_i.rs1);
    assign fwd2 = busy2_i && last2_i && wb_write && (wb_i.rd == issue_i.rs2);

    assign haz1 = issue_i.read_rs1 && busy1_i && !fwd1;
    assign haz2 = issue_i.read_rs2 && busy2_i && !fwd2;

    // Destination counter has no room
    assign rd_block  = issue_i.write_rd && (issue_i.rd != '0) && rd_full_i;
    assign no_credit = (rq_cred_q == '0);

    assign stall_o      = issue_valid_i && (haz1 || haz2 || rd_block || no_credit);
    assign issue_fire_o = issue_valid_i && !stall_o;

    // ----------------------------------------
    // Operand select
    // ----------------------------------------
    always_comb begin
        // Unread sources give zero
        op_a = '0;
        op_b = '0;
        if (issue_i.read_rs1) begin
            op_a = fwd1 ? wb_i.data : rs1_data_i;
        end
        if (issue_i.read_rs2) begin
            op_b = fwd2 ? wb_i.data : rs2_data_i;
        end
        // Immediate replaces b
        if (issue_i.use_imm) begin
            op_b = issue_i.imm;
        end
    end

    assign exec_o.op       = issue_i.op;
    assign exec_o.rd       = issue_i.rd;
    assign exec_o.write_rd = issue_i.write_rd;
    assign exec_o.a        = op_a;
    assign exec_o.b        = op_b;

    // Queue credits, one spent per issue
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rq_cred_q <= rf_pkg::rq_cnt_t'(rf_pkg::RQ_DEPTH);
        end else begin
            case ({issue_fire_o, rq_credit_i})
                2'b10:   rq_cred_q <= rq_cred_q - rf_pkg::rq_cnt_t'(1);
                2'b01:   rq_cred_q <= rq_cred_q + rf_pkg::rq_cnt_t'(1);
                default: rq_cred_q <= rq_cred_q;
            endcase
        end
    end

    // Queue never returns more than was spent
    a_rq_cred_range: assert property (@(posedge clk_i) disable iff (!rst_i)
        rq_cred_q <= rf_pkg::rq_cnt_t'(rf_pkg::RQ_DEPTH));

endmodule

//--- logic/alu_pipe.sv
`timescale 1ns/1ns

module alu_pipe (
    input  logic              clk_i,
    input  logic              rst_i,

    // From issue
    input  logic              issue_fire_i,
    input  rf_pkg::exec_req_t exec_i,
    output logic              rq_credit_o,

    // Write-back port
    input  logic              wb_credit_i,
    output logic              wb_fire_o,
    output rf_pkg::wb_t       wb_o
);

    // Stage 1 request
    logic              s1_valid_q;
    rf_pkg::exec_req_t s1_q;

    // Stage 2 result
    logic              s2_valid_q;
    rf_pkg::wb_t       s2_q;
    rf_pkg::word_t     alu_res;

    // Result queue
    rf_pkg::wb_t       rq_mem [rf_pkg::RQ_DEPTH];
    rf_pkg::rq_ptr_t   wr_ptr_q;
    rf_pkg::rq_ptr_t   rd_ptr_q;
    rf_pkg::rq_cnt_t   rq_cnt_q;
    rf_pkg::wb_cnt_t   wb_cred_q;

    logic push;
    logic pop;
    logic empty;
    logic full;

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_fire_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        s1_q         <= exec_i;
        s2_q.rd       <= s1_q.rd;
        s2_q.write_rd <= s1_q.write_rd;
        s2_q.data     <= alu_res;
    end

    // Opcode result with shifts on the low bits of b
    always_comb begin
        case (s1_q.op)
            rf_pkg::OP_ADD: alu_res = s1_q.a + s1_q.b;
            rf_pkg::OP_SUB: alu_res = s1_q.a - s1_q.b;
            rf_pkg::OP_AND: alu_res = s1_q.a & s1_q.b;
            rf_pkg::OP_OR:  alu_res = s1_q.a | s1_q.b;
            rf_pkg::OP_XOR: alu_res = s1_q.a ^ s1_q.b;
            rf_pkg::OP_SLL: alu_res = s1_q.a << s1_q.b[rf_pkg::SHAMT_W-1:0];
            rf_pkg::OP_SRL: alu_res = s1_q.a >> s1_q.b[rf_pkg::SHAMT_W-1:0];
            default:        alu_res = '0;
        endcase
    end

    // ----------------------------------------
    // Result queue
    // ----------------------------------------

    assign push  = s2_valid_q;
    assign empty = (rq_cnt_q == '0);
    assign full  = (rq_cnt_q == rf_pkg::rq_cnt_t'(rf_pkg::RQ_DEPTH));
    // Head leaves whenever the sink has credit
    assign pop   = !empty && (wb_cred_q != '0);

    always_ff @(posedge clk_i) begin
        if (push) begin
            rq_mem[wr_ptr_q] <= s2_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            rq_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + rf_pkg::rq_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + rf_pkg::rq_ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   rq_cnt_q <= rq_cnt_q + rf_pkg::rq_cnt_t'(1);
                2'b01:   rq_cnt_q <= rq_cnt_q - rf_pkg::rq_cnt_t'(1);
                default: rq_cnt_q <= rq_cnt_q;
            endcase
        end
    end

    // Sink credit counter
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_cred_q <= rf_pkg::wb_cnt_t'(rf_pkg::WB_CREDITS);
        end else begin
            case ({pop, wb_credit_i})
                2'b10:   wb_cred_q <= wb_cred_q - rf_pkg::wb_cnt_t'(1);
                2'b01:   wb_cred_q <= wb_cred_q + rf_pkg::wb_cnt_t'(1);
                default: wb_cred_q <= wb_cred_q;
            endcase
        end
    end

    assign wb_fire_o   = pop;
    assign wb_o        = rq_mem[rd_ptr_q];
    // Leaving entry frees an issue credit
    assign rq_credit_o = pop;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Issue credits keep the queue from overflowing
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_i)
        push |-> !full);

    // Sink returns credit only for results it has consumed
    a_wb_cred_bound: assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_credit_i |-> (int'(wb_cred_q) - int'(pop)) < rf_pkg::WB_CREDITS);

endmodule

//--- logic/regfile_subsys.sv
`timescale 1ns/1ns

module regfile_subsys (
    input  logic               clk_i,
    input  logic               rst_i,

    // Issue port
    input  logic               issue_valid_i,
    input  rf_pkg::issue_req_t issue_i,
    output logic               stall_o,

    // Write-back port
    output logic               wb_valid_o,
    output rf_pkg::wb_t        wb_o,
    input  logic               wb_credit_i
);

    // Storage reads
    rf_pkg::reg_idx_t  rs1_addr;
    rf_pkg::reg_idx_t  rs2_addr;
    rf_pkg::word_t     rs1_data;
    rf_pkg::word_t     rs2_data;

    // Scoreboard flags
    logic busy1;
    logic busy2;
    logic last1;
    logic last2;
    logic rd_full;

    // Issue to ALU
    logic              issue_fire;
    rf_pkg::exec_req_t exec_req;
    logic              rq_credit;

    // ----------------------------------------
    // Blocks
    // ----------------------------------------

    reg_storage u_storage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_fire_i  (wb_valid_o),
        .wb_i       (wb_o)
    );

    // Looks up the same sources the storage reads
    reg_scoreboard u_scoreboard (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rs1_i         (rs1_addr),
        .rs2_i         (rs2_addr),
        .rd_i          (issue_i.rd),
        .issue_fire_i  (issue_fire),
        .issue_write_i (issue_i.write_rd),
        .wb_fire_i     (wb_valid_o),
        .wb_i          (wb_o),
        .busy1_o       (busy1),
        .busy2_o       (busy2),
        .last1_o       (last1),
        .last2_o       (last2),
        .rd_full_o     (rd_full)
    );

    operand_issue u_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_o       (stall_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .busy1_i       (busy1),
        .busy2_i       (busy2),
        .last1_i       (last1),
        .last2_i       (last2),
        .rd_full_i     (rd_full),
        .wb_fire_i     (wb_valid_o),
        .wb_i          (wb_o),
        .rq_credit_i   (rq_credit),
        .issue_fire_o  (issue_fire),
        .exec_o        (exec_req)
    );

    alu_pipe u_alu (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_fire_i (issue_fire),
        .exec_i       (exec_req),
        .rq_credit_o  (rq_credit),
        .wb_credit_i  (wb_credit_i),
        .wb_fire_o    (wb_valid_o),
        .wb_o         (wb_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10;
            clk_o = ~clk_o;
        end
    end

    // Active low reset over the first 4 rising edges
    initial begin
        rst_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2;
        rst_o = 1'b1;
    end

endmodule

//--- tb/tb_regfile_subsys.sv
`timescale 1ns/1ns

module tb_regfile_subsys;

    logic               clk_i;
    logic               rst_i;
    logic               issue_valid_i;
    rf_pkg::issue_req_t issue_i;
    logic               stall_o;
    logic               wb_valid_o;
    rf_pkg::wb_t        wb_o;
    logic               wb_credit_i;

    // Stimulus side
    logic [31:0]   lfsr_state;
    int            cred_delay [256];
    int            hold_end;
    int            seq_errors;
    bit            timed_out;

    // Monitor and reference model
    rf_pkg::word_t arch_regs [rf_pkg::NUM_REGS];
    rf_pkg::wb_t   exp_q [$];
    int            cred_due [$];
    int            cycle_cnt;
    int            accepted;
    int            wb_count;
    int            cred_returned;
    int            mon_errors;
    bit            hold_stall_seen;
    logic          credit_next;

    tb_clock_gen u_clk (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    regfile_subsys dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .wb_credit_i   (wb_credit_i)
    );

    // ----------------------------------------
    // Random source and reference ALU
    // ----------------------------------------

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic rf_pkg::word_t model_alu(input rf_pkg::alu_op_e op,
                                                input rf_pkg::word_t a,
                                                input rf_pkg::word_t b);
        case (op)
            rf_pkg::OP_ADD: return a + b;
            rf_pkg::OP_SUB: return a - b;
            rf_pkg::OP_AND: return a & b;
            rf_pkg::OP_OR:  return a | b;
            rf_pkg::OP_XOR: return a ^ b;
            rf_pkg::OP_SLL: return a << b[4:0];
            rf_pkg::OP_SRL: return a >> b[4:0];
            default:        return '0;
        endcase
    endfunction

    // Registers x0..x7 only, so hazards are frequent
    function automatic rf_pkg::issue_req_t make_req(input bit chain,
                                                    input rf_pkg::reg_idx_t prev_rd);
        rf_pkg::issue_req_t r;
        logic [2:0]         opv;
        opv = 3'(rand_bits(3));
        if (opv == 3'd7) begin
            opv = 3'd0;
        end
        r.op       = rf_pkg::alu_op_e'(opv);
        r.rs1      = rf_pkg::reg_idx_t'(rand_bits(3));
        r.rs2      = rf_pkg::reg_idx_t'(rand_bits(3));
        r.rd       = rf_pkg::reg_idx_t'(rand_bits(3));
        r.read_rs1 = (rand_bits(1) != 0);
        r.read_rs2 = (rand_bits(1) != 0);
        r.write_rd = (rand_bits(3) != 0);
        r.use_imm  = (rand_bits(2) == 0);
        r.imm      = rand_bits(32);
        // Chain link reads the previous destination
        if (chain) begin
            r.rs1      = prev_rd;
            r.read_rs1 = 1'b1;
            r.write_rd = 1'b1;
            if (r.rd == '0) begin
                r.rd = 5'd1;
            end
        end
        return r;
    endfunction

    // ----------------------------------------
    // Monitor helpers
    // ----------------------------------------

    // Program order result of an accepted instruction
    function void accept_model(input rf_pkg::issue_req_t r);
        rf_pkg::word_t a;
        rf_pkg::word_t b;
        rf_pkg::wb_t   e;
        a = r.read_rs1 ? arch_regs[r.rs1] : '0;
        b = r.read_rs2 ? arch_regs[r.rs2] : '0;
        if (r.use_imm) begin
            b = r.imm;
        end
        e.rd       = r.rd;
        e.write_rd = r.write_rd;
        e.data     = model_alu(r.op, a, b);
        exp_q.push_back(e);
        // x0 never written
        if (r.write_rd && (r.rd != '0)) begin
            arch_regs[r.rd] = e.data;
        end
        accepted++;
    endfunction

    function void check_wb();
        rf_pkg::wb_t e;
        // Pop only on a credit returned before this cycle
        a_wb_bound: assert (wb_count < cred_returned + rf_pkg::WB_CREDITS) else begin
            mon_errors++;
            $display("Fail %0t: write-back %0d sent with %0d credits returned", $time,
                     wb_count + 1, cred_returned);
        end
        a_wb_expected: assert (exp_q.size() > 0) else begin
            mon_errors++;
            $display("Write-back at %0t arrived with no result outstanding", $time);
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            a_wb_match: assert (wb_o == e) else begin
                mon_errors++;
                $display("Fail %0t: got rd %0d wr %0b data %08h, expected rd %0d wr %0b data %08h",
                         $time, wb_o.rd, wb_o.write_rd, wb_o.data, e.rd, e.write_rd, e.data);
            end
        end
        cred_due.push_back(cred_delay[wb_count % 256]);
        wb_count++;
    endfunction

    // Oldest consumed result whose delay ran out frees one credit
    function void schedule_credit();
        credit_next = 1'b0;
        if ((cycle_cnt >= hold_end) && (cred_due.size() > 0) && (cred_due[0] == 0)) begin
            void'(cred_due.pop_front());
            credit_next = 1'b1;
        end
        foreach (cred_due[k]) begin
            if (cred_due[k] > 0) begin
                cred_due[k]--;
            end
        end
    endfunction

    // Sampled at the falling edge, where DUT outputs are settled
    initial begin
        cycle_cnt       = 0;
        accepted        = 0;
        wb_count        = 0;
        cred_returned   = 0;
        mon_errors      = 0;
        hold_stall_seen = 1'b0;
        credit_next     = 1'b0;
        for (int i = 0; i < rf_pkg::NUM_REGS; i++) begin
            arch_regs[i] = '0;
        end
        forever begin
            @(negedge clk_i);
            cycle_cnt++;
            if (!rst_i || (accepted == 0)) begin
                a_idle_wb: assert (!wb_valid_o) else begin
                    mon_errors++;
                    $display("Fail %0t: write-back valid before any instruction", $time);
                end
            end
            if (rst_i) begin
                if (wb_valid_o) begin
                    check_wb();
                end
                if (wb_credit_i) begin
                    cred_returned++;
                end
                if (issue_valid_i && !stall_o) begin
                    accept_model(issue_i);
                end
                if ((cycle_cnt < hold_end) && issue_valid_i && stall_o) begin
                    hold_stall_seen = 1'b1;
                end
                schedule_credit();
            end
        end
    end

    // Sink credit pulses
    initial begin
        wb_credit_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            wb_credit_i = credit_next;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // Called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic drive_instr(input rf_pkg::issue_req_t req);
        int waited;
        issue_i       = req;
        issue_valid_i = 1'b1;
        waited        = 0;
        @(negedge clk_i);
        while (stall_o && (waited < 200)) begin
            @(negedge clk_i);
            waited++;
        end
        if (stall_o) begin
            timed_out = 1'b1;
            $display("Timeout: instruction held by stall for %0d cycles at %0t", waited, $time);
        end
        @(posedge clk_i);
        #2;
        issue_valid_i = 1'b0;
    endtask

    initial begin
        rf_pkg::issue_req_t req;
        rf_pkg::reg_idx_t   prev_rd;
        int                 gap;
        int                 waited;
        int                 total;

        lfsr_state    = 32'd95648;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        hold_end      = 0;
        seq_errors    = 0;
        timed_out     = 1'b0;
        prev_rd       = '0;

        // Credit return delays of 0 to 5 cycles
        foreach (cred_delay[k]) begin
            cred_delay[k] = int'(rand_bits(3)) % 6;
        end

        waited = 0;
        while ((rst_i !== 1'b1) && (waited < 20)) begin
            @(posedge clk_i);
            waited++;
        end
        if (rst_i !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end
        @(posedge clk_i);
        #2;

        // Random mix, half the links chained, half with no gap
        for (int n = 0; (n < 300) && !timed_out; n++) begin
            gap = (rand_bits(1) != 0) ? 0 : int'(rand_bits(2));
            repeat (gap) begin
                @(posedge clk_i);
                #2;
            end
            req = make_req(rand_bits(1) != 0, prev_rd);
            drive_instr(req);
            prev_rd = req.rd;
        end

        // Back-to-back dependent chain
        for (int n = 0; (n < 40) && !timed_out; n++) begin
            req = make_req(1'b1, prev_rd);
            drive_instr(req);
            prev_rd = req.rd;
        end

        // Sink holds its credits, the queue fills and issue must stall
        hold_end = cycle_cnt + 60;
        for (int n = 0; (n < 10) && !timed_out; n++) begin
            req = make_req(1'b0, prev_rd);
            drive_instr(req);
            prev_rd = req.rd;
        end
        a_hold_stall: assert (timed_out || hold_stall_seen) else begin
            seq_errors++;
            $display("Issue port never stalled while write-back credits were held");
        end

        // Drain all outstanding results
        waited = 0;
        while (!timed_out && (exp_q.size() > 0) && (waited < 500)) begin
            @(negedge clk_i);
            waited++;
        end
        if (!timed_out && (exp_q.size() > 0)) begin
            timed_out = 1'b1;
            $display("Timeout: %0d results never left the queue", exp_q.size());
        end
        a_drain_count: assert (timed_out || (wb_count == accepted)) else begin
            seq_errors++;
            $display("Fail %0t: %0d write-backs for %0d accepted", $time, wb_count, accepted);
        end

        total = seq_errors + mon_errors;
        $display("Errors %0d (sequence %0d, monitor %0d), accepted %0d, write-backs %0d",
                 total, seq_errors, mon_errors, accepted, wb_count);
        if ((total == 0) && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/rf_pkg.sv
logic/reg_storage.sv
logic/reg_scoreboard.sv
logic/operand_issue.sv
logic/alu_pipe.sv
logic/regfile_subsys.sv
tb/tb_clock_gen.sv
tb/tb_regfile_subsys.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module tb_regfile_subsys \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
